// ==== design/ifmap_defs.svh ====
`ifndef IFMAP_DEFS_SVH
`define IFMAP_DEFS_SVH

// GLB geometry
// Address width must cover GLB_DEPTH words
`define GLB_ADDR_W 10
`define GLB_DATA_W 32
`define GLB_DEPTH 1024

// Staging FIFO between the GLB and the PE array
// Kept a power of two so the pointers wrap on their own
`define IFMAP_FIFO_DEPTH 8

// Width of the per-task pop count from the L2 controller
`define POP_NUM_W 5

`endif

// ==== design/glb_pkg.sv ====
`include "ifmap_defs.svh"

package glb_pkg;

    // Word address into the global buffer
    typedef logic [`GLB_ADDR_W-1:0] glb_addr_t;

    // One ifmap word as stored in the GLB and the FIFO
    typedef logic [`GLB_DATA_W-1:0] glb_data_t;

endpackage

// ==== design/ifmap_ctrl_pkg.sv ====
`include "ifmap_defs.svh"

package ifmap_ctrl_pkg;

    // Task sequencer states
    typedef enum logic [1:0] {
        IDLE,
        POP,
        PUSH
    } ifmap_state_t;

    // Number of pops requested for one task
    typedef logic [`POP_NUM_W-1:0] pop_num_t;

endpackage

// ==== design/glb_sram.sv ====
`timescale 1ns/1ps
`include "ifmap_defs.svh"

module glb_sram (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we_i,
    input  glb_pkg::glb_addr_t addr_i,
    input  glb_pkg::glb_data_t wdata_i,
    output glb_pkg::glb_data_t rdata_o
);
    import glb_pkg::*;

    localparam int DEPTH = `GLB_DEPTH;

    // Single-port word array
    glb_data_t mem [DEPTH];

    // Write on the rising edge; no writes accepted while held in reset
    always_ff @(posedge clk) begin
        if (we_i && rst_n) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // Read data follows the address in the same cycle
    assign rdata_o = mem[addr_i];

endmodule

// ==== design/glb_port_arbiter.sv ====
`timescale 1ns/1ps

module glb_port_arbiter (
    // Loader side, write only
    input  logic               load_we_i,
    input  glb_pkg::glb_addr_t load_addr_i,
    input  glb_pkg::glb_data_t load_data_i,

    // Ifmap path side, read only
    input  logic               rd_req_i,
    input  glb_pkg::glb_addr_t rd_addr_i,
    output logic               permit_o,

    // Shared SRAM port
    output logic               sram_we_o,
    output glb_pkg::glb_addr_t sram_addr_o,
    output glb_pkg::glb_data_t sram_wdata_o,
    input  glb_pkg::glb_data_t sram_rdata_i,
    output glb_pkg::glb_data_t rd_data_o
);
    import glb_pkg::*;

    // Port owner this cycle
    logic      load_grant;
    logic      rd_grant;
    glb_addr_t port_addr;

    // Loader always wins and is never stalled
    assign load_grant = load_we_i;
    assign rd_grant   = rd_req_i && !load_we_i;

    // Address mux onto the shared port
    always_comb begin
        if (load_grant) begin
            port_addr = load_addr_i;
        end else begin
            port_addr = rd_addr_i;
        end
    end

    assign sram_addr_o  = port_addr;
    assign sram_we_o    = load_grant;
    assign sram_wdata_o = load_data_i;

    // A blocked read simply retries next cycle, the requester holds its address
    assign permit_o = rd_grant;

    // Combinational SRAM read goes straight back to the reader
    assign rd_data_o = sram_rdata_i;

endmodule

// ==== design/ifmap_fifo.sv ====
`timescale 1ns/1ps
`include "ifmap_defs.svh"

module ifmap_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear_i,
    input  logic               push_i,
    input  glb_pkg::glb_data_t push_data_i,
    input  logic               pop_i,
    output glb_pkg::glb_data_t head_o,
    output logic               full_o,
    output logic               empty_o
);
    import glb_pkg::*;

    localparam int DEPTH = `IFMAP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    glb_data_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Requests past the flags are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
        end
    end

    // Occupancy, unchanged on a simultaneous push and pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear_i) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10: count <= count + CNT_W'(1);
                2'b01: count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);

    // Show-ahead head word
    assign head_o = mem[rd_ptr];

endmodule

// ==== design/ifmap_fifo_ctrl.sv ====
`timescale 1ns/1ps

module ifmap_fifo_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear_i,

    // Task request from the L2 controller
    input  logic                     need_pop_i,
    input  ifmap_ctrl_pkg::pop_num_t pop_num_i,

    // Arbiter grant and FIFO flags
    input  logic                     permit_push_i,
    input  logic                     fifo_full_i,
    input  logic                     fifo_empty_i,

    // GLB read side
    input  glb_pkg::glb_addr_t       glb_base_addr_i,
    input  glb_pkg::glb_data_t       glb_read_data_i,

    // FIFO write and read strobes
    output logic                     push_en_o,
    output glb_pkg::glb_data_t       push_data_o,
    output logic                     pop_en_o,

    // Request to the arbiter
    output logic                     glb_read_req_o,
    output glb_pkg::glb_addr_t       glb_read_addr_o,

    output logic                     done_o
);
    import glb_pkg::*;
    import ifmap_ctrl_pkg::*;

    ifmap_state_t state;
    ifmap_state_t state_nxt;
    pop_num_t     pop_num_q;
    pop_num_t     pop_cnt;
    pop_num_t     last_idx;
    glb_addr_t    read_ptr;
    logic         zero_task;
    logic         last_pop;

    assign zero_task = (pop_num_q == '0);
    assign last_idx  = pop_num_q - pop_num_t'(1);

    // Task ends on the pop that carries the final index
    assign last_pop = pop_en_o && (pop_cnt == last_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (need_pop_i) begin
                    state_nxt = POP;
                end
            end
            POP: begin
                if (zero_task || last_pop) begin
                    state_nxt = IDLE;
                end else if (fifo_empty_i) begin
                    state_nxt = PUSH;
                end
            end
            PUSH: begin
                // Refill runs until the FIFO is full
                if (fifo_full_i) begin
                    state_nxt = POP;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Count is sampled every idle cycle, so the value at need_pop wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_num_q <= '0;
        end else if (state == IDLE) begin
            pop_num_q <= pop_num_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_cnt <= '0;
        end else if (state == IDLE) begin
            pop_cnt <= '0;
        end else if (pop_en_o) begin
            pop_cnt <= pop_cnt + pop_num_t'(1);
        end
    end

    // Read pointer survives across tasks until a clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_ptr <= '0;
        end else if (clear_i) begin
            read_ptr <= '0;
        end else if (push_en_o) begin
            read_ptr <= read_ptr + glb_addr_t'(1);
        end
    end

    // Wraps at GLB_DEPTH through the address width
    assign glb_read_addr_o = glb_base_addr_i + read_ptr;

    assign glb_read_req_o = (state == PUSH) && !fifo_full_i;
    assign push_en_o      = (state == PUSH) && permit_push_i && !fifo_full_i;
    assign push_data_o    = glb_read_data_i;

    assign pop_en_o = (state == POP) && !fifo_empty_i && !zero_task;
    assign done_o   = (state == IDLE);

endmodule

// ==== design/ifmap_buffer_top.sv ====
`timescale 1ns/1ps

module ifmap_buffer_top (
    input  logic                     clk,
    input  logic                     rst_n,

    // Loader write port
    input  logic                     load_we_i,
    input  glb_pkg::glb_addr_t       load_addr_i,
    input  glb_pkg::glb_data_t       load_data_i,

    // Task control
    input  logic                     ifmap_clear_i,
    input  logic                     ifmap_need_pop_i,
    input  ifmap_ctrl_pkg::pop_num_t ifmap_pop_num_i,
    input  glb_pkg::glb_addr_t       ifmap_glb_base_addr_i,

    // Stream to the PE array
    output glb_pkg::glb_data_t       ifmap_data_o,
    output logic                     ifmap_data_valid_o,
    output logic                     ifmap_done_o
);

    logic               glb_read_req;
    glb_pkg::glb_addr_t glb_read_addr;
    glb_pkg::glb_data_t glb_read_data;
    logic               permit_push;
    logic               sram_we;
    glb_pkg::glb_addr_t sram_addr;
    glb_pkg::glb_data_t sram_wdata;
    glb_pkg::glb_data_t sram_rdata;
    logic               push_en;
    glb_pkg::glb_data_t push_data;
    logic               pop_en;
    logic               fifo_full;
    logic               fifo_empty;

    glb_sram u_glb_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .we_i    (sram_we),
        .addr_i  (sram_addr),
        .wdata_i (sram_wdata),
        .rdata_o (sram_rdata)
    );

    glb_port_arbiter u_glb_port_arbiter (
        .load_we_i    (load_we_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .rd_req_i     (glb_read_req),
        .rd_addr_i    (glb_read_addr),
        .permit_o     (permit_push),
        .sram_we_o    (sram_we),
        .sram_addr_o  (sram_addr),
        .sram_wdata_o (sram_wdata),
        .sram_rdata_i (sram_rdata),
        .rd_data_o    (glb_read_data)
    );

    ifmap_fifo u_ifmap_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (ifmap_clear_i),
        .push_i      (push_en),
        .push_data_i (push_data),
        .pop_i       (pop_en),
        .head_o      (ifmap_data_o),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    ifmap_fifo_ctrl u_ifmap_fifo_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .clear_i         (ifmap_clear_i),
        .need_pop_i      (ifmap_need_pop_i),
        .pop_num_i       (ifmap_pop_num_i),
        .permit_push_i   (permit_push),
        .fifo_full_i     (fifo_full),
        .fifo_empty_i    (fifo_empty),
        .glb_base_addr_i (ifmap_glb_base_addr_i),
        .glb_read_data_i (glb_read_data),
        .push_en_o       (push_en),
        .push_data_o     (push_data),
        .pop_en_o        (pop_en),
        .glb_read_req_o  (glb_read_req),
        .glb_read_addr_o (glb_read_addr),
        .done_o          (ifmap_done_o)
    );

    // Head word is consumed in the cycle the pop strobe is high
    assign ifmap_data_valid_o = pop_en;

endmodule

// ==== tests/tb_ifmap_buffer.sv ====
`timescale 1ns/1ps
`include "ifmap_defs.svh"

module tb_ifmap_buffer;
    import glb_pkg::*;
    import ifmap_ctrl_pkg::*;

    // Preload of the whole GLB plus six tasks of up to 31 pops with refills
    localparam int TIMEOUT_CYCLES = 5000;

    logic      clk;
    logic      rst_n;
    logic      load_we;
    glb_addr_t load_addr;
    glb_data_t load_data;
    logic      ifmap_clear;
    logic      ifmap_need_pop;
    pop_num_t  ifmap_pop_num;
    glb_addr_t ifmap_base;
    glb_data_t ifmap_data;
    logic      ifmap_data_valid;
    logic      ifmap_done;

    // Reference copy of the GLB and the pop-based read pointer
    glb_data_t model_mem [`GLB_DEPTH];
    int        model_ptr;
    glb_addr_t cur_base;
    integer    seed;
    int        cycle_cnt;
    int        test_errors;
    int        tests_passed;
    int        tests_failed;
    int        blocked_reads;
    glb_data_t got_words [$];

    ifmap_buffer_top dut_i (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .load_we_i             (load_we),
        .load_addr_i           (load_addr),
        .load_data_i           (load_data),
        .ifmap_clear_i         (ifmap_clear),
        .ifmap_need_pop_i      (ifmap_need_pop),
        .ifmap_pop_num_i       (ifmap_pop_num),
        .ifmap_glb_base_addr_i (ifmap_base),
        .ifmap_data_o          (ifmap_data),
        .ifmap_data_valid_o    (ifmap_data_valid),
        .ifmap_done_o          (ifmap_done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("ERROR: simulation hung, still running after %0d cycles", cycle_cnt);
        $display("Something failed");
        $finish;
    end

    task automatic wait_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic preload_glb();
        int i;
        for (i = 0; i < `GLB_DEPTH; i++) begin
            wait_drive_slot();
            load_we   = 1'b1;
            load_addr = glb_addr_t'(i);
            load_data = $random(seed);
            model_mem[i] = load_data;
        end
        wait_drive_slot();
        load_we = 1'b0;
    endtask

    // Pulse need_pop and gather every valid word until done rises
    task automatic run_pop_task(input string name, input int n, input bit disturb);
        int cyc;
        bit finished;
        got_words.delete();
        blocked_reads = 0;
        cyc = 0;
        finished = 1'b0;
        wait_drive_slot();
        ifmap_need_pop = 1'b1;
        ifmap_pop_num  = pop_num_t'(n);
        ifmap_base     = cur_base;
        wait_drive_slot();
        ifmap_need_pop = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (cyc == 0 && ifmap_done !== 1'b0) begin
                $display("FAIL %s: done one cycle after request expected 0 actual %b",
                         name, ifmap_done);
                test_errors++;
            end
            if (load_we && dut_i.glb_read_req) begin
                blocked_reads++;
            end
            if (ifmap_data_valid) begin
                got_words.push_back(ifmap_data);
            end
            if (ifmap_done) begin
                finished = 1'b1;
            end else begin
                wait_drive_slot();
                // Loader writes near the top of the GLB, away from the read window
                if (disturb && (cyc % 2 == 0)) begin
                    load_we   = 1'b1;
                    load_addr = glb_addr_t'(960 + (cyc % 64));
                    load_data = $random(seed);
                    model_mem[load_addr] = load_data;
                end else begin
                    load_we = 1'b0;
                end
                cyc++;
            end
        end
        if (disturb) begin
            wait_drive_slot();
            load_we = 1'b0;
        end
    endtask

    // Expected word is model[base + pointer] with the pointer advancing per pop
    task automatic check_words(input string name, input int n);
        int        i;
        glb_addr_t addr;
        glb_data_t exp;
        if (got_words.size() != n) begin
            $display("FAIL %s: word count expected %0d actual %0d", name, n, got_words.size());
            test_errors++;
        end
        for (i = 0; i < got_words.size(); i++) begin
            addr = glb_addr_t'(int'(cur_base) + model_ptr);
            exp  = model_mem[addr];
            if (got_words[i] !== exp) begin
                $display("FAIL %s: word %0d expected %h actual %h", name, i, exp, got_words[i]);
                test_errors++;
            end
            model_ptr++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("%s finished with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic test_first_task();
        @(negedge clk);
        if (ifmap_done !== 1'b1) begin
            $display("FAIL first_task: done after reset expected 1 actual %b", ifmap_done);
            test_errors++;
        end
        if (ifmap_data_valid !== 1'b0) begin
            $display("FAIL first_task: valid after reset expected 0 actual %b",
                     ifmap_data_valid);
            test_errors++;
        end
        if (dut_i.glb_read_req !== 1'b0) begin
            $display("FAIL first_task: read request after reset expected 0 actual %b",
                     dut_i.glb_read_req);
            test_errors++;
        end
        if (dut_i.push_en !== 1'b0) begin
            $display("FAIL first_task: push after reset expected 0 actual %b",
                     dut_i.push_en);
            test_errors++;
        end
        preload_glb();
        cur_base = glb_addr_t'(16);
        run_pop_task("first_task", 5, 1'b0);
        check_words("first_task", 5);
        finish_test("first_task");
    endtask

    task automatic test_clear_new_base();
        wait_drive_slot();
        ifmap_clear = 1'b1;
        cur_base    = glb_addr_t'(200);
        ifmap_base  = cur_base;
        wait_drive_slot();
        ifmap_clear = 1'b0;
        model_ptr   = 0;
        @(negedge clk);
        if (dut_i.fifo_empty !== 1'b1) begin
            $display("FAIL clear_new_base: FIFO empty after clear expected 1 actual %b",
                     dut_i.fifo_empty);
            test_errors++;
        end
        run_pop_task("clear_new_base", 10, 1'b0);
        check_words("clear_new_base", 10);
        finish_test("clear_new_base");
    endtask

    task automatic test_loader_contention();
        // Leaves two words in the FIFO for the zero-count task
        run_pop_task("loader_contention", 28, 1'b1);
        check_words("loader_contention", 28);
        if (blocked_reads == 0) begin
            $display("ERROR loader_contention: no loader write overlapped a refill read");
            test_errors++;
        end
        finish_test("loader_contention");
    endtask

    initial begin
        seed           = 36226;
        model_ptr      = 0;
        cur_base       = '0;
        test_errors    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        blocked_reads  = 0;
        rst_n          = 1'b0;
        load_we        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        ifmap_clear    = 1'b0;
        ifmap_need_pop = 1'b0;
        ifmap_pop_num  = '0;
        ifmap_base     = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_first_task();

        // Longer than the FIFO depth so several refills run
        run_pop_task("long_refill", 20, 1'b0);
        check_words("long_refill", 20);
        finish_test("long_refill");

        // Leftover words from the last task come out first
        run_pop_task("continue_no_clear", 12, 1'b0);
        check_words("continue_no_clear", 12);
        finish_test("continue_no_clear");

        test_clear_new_base();
        test_loader_contention();

        run_pop_task("zero_count", 0, 1'b0);
        check_words("zero_count", 0);
        finish_test("zero_count");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/glb_pkg.sv
design/ifmap_ctrl_pkg.sv
design/glb_sram.sv
design/glb_port_arbiter.sv
design/ifmap_fifo.sv
design/ifmap_fifo_ctrl.sv
design/ifmap_buffer_top.sv
tests/tb_ifmap_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ifmap buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --top-module tb_ifmap_buffer \
    -Mdir obj_dir -o tb_ifmap_buffer -f filelist.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ifmap_buffer > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Something failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
